//--- files.f
+incdir+tests
verilog/tomasulo_pkg.sv
verilog/int_alu.sv
verilog/alu_rs.sv
verilog/cdb_arbiter.sv
verilog/int_exec_top.sv
tests/tb_int_exec.sv

//--- Bender.yml
package:
  name: tomasulo_int_exec

sources:
  - files:
      - verilog/tomasulo_pkg.sv
      - verilog/int_alu.sv
      - verilog/alu_rs.sv
      - verilog/cdb_arbiter.sv
      - verilog/int_exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_int_exec.sv

//--- tests/tb_int_exec_table.svh
// each row holds cluster (0 = a, 1 = b), op, dep1, val1, dep2, val2 and dest tag
// dep LIT uses val as data
// dep RAW waits on the tag held in val
// any other dep is the index of the row that produces the operand
localparam int LIT = -1;
localparam int RAW = -2;

typedef struct {
    int              cluster;
    alu_op_e         op;
    int              dep1;
    logic [XLEN-1:0] val1;
    int              dep2;
    logic [XLEN-1:0] val2;
    int              dest;
} row_t;

// end index of each section
localparam int OPS_END    = 10;
localparam int CHAIN_END  = 16;
localparam int FULL_END   = 22;
localparam int FLUSH_END  = 30;
localparam int TABLE_ROWS = 34;

row_t table_rows [TABLE_ROWS] = '{
    '{0, ADD, LIT, 32'h0000_0005, LIT, 32'h0000_0007, 0},
    '{1, SUB, LIT, 32'h0000_0003, LIT, 32'h0000_000a, 1},
    '{0, AND, LIT, 32'hf0f0_ff00, LIT, 32'h0ff0_0f0f, 2},
    '{1, OR,  LIT, 32'h1234_0000, LIT, 32'h0000_5678, 3},
    '{0, XOR, LIT, 32'haaaa_5555, LIT, 32'hffff_0000, 4},
    // shift amounts above 31 wrap to the low 5 bits
    '{1, SLL, LIT, 32'h0000_0001, LIT, 32'h0000_0024, 5},
    '{0, SRL, LIT, 32'h8000_0000, LIT, 32'hffff_ffe1, 6},
    '{1, SLT, LIT, 32'hffff_fff6, LIT, 32'h0000_0003, 7},
    '{0, SLT, LIT, 32'h0000_0005, LIT, 32'hffff_fffb, 8},
    '{1, SLT, LIT, 32'h8000_0000, LIT, 32'h7fff_ffff, 9},
    // chain where each op waits on the one before
    '{0, ADD, LIT, 32'h0000_0064, LIT, 32'h0000_0001, 10},
    '{0, SUB, 10,  32'h0,         LIT, 32'h0000_0003, 11},
    '{1, SLL, 11,  32'h0,         LIT, 32'h0000_0002, 12},
    '{0, XOR, 12,  32'h0,         11,  32'h0,         13},
    '{1, SLT, 13,  32'h0,         10,  32'h0,         14},
    // src2 is dispatched in the cycle that tag 10 is on the cdb
    '{1, ADD, 14,  32'h0,         10,  32'h0,         15},
    // cluster b fills up waiting on row 20 from cluster a
    '{1, ADD, 20,  32'h0,         LIT, 32'h0000_0001, 0},
    '{1, SUB, 20,  32'h0,         LIT, 32'h0000_0010, 1},
    '{1, SRL, 20,  32'h0,         LIT, 32'h0000_0003, 2},
    '{1, OR,  20,  32'h0,         20,  32'h0,         3},
    '{0, ADD, LIT, 32'h0000_1000, LIT, 32'h0000_0234, 4},
    '{1, ADD, 16,  32'h0,         LIT, 32'h0000_0005, 5},
    // both clusters fill up with ops parked on tag 9 until the flush
    '{0, ADD, RAW, 32'h0000_0009, LIT, 32'h0000_0001, 6},
    '{0, SUB, LIT, 32'h0000_0040, RAW, 32'h0000_0009, 7},
    '{0, XOR, RAW, 32'h0000_0009, RAW, 32'h0000_0009, 8},
    '{0, OR,  RAW, 32'h0000_0009, LIT, 32'h0000_0003, 10},
    '{1, AND, RAW, 32'h0000_0009, LIT, 32'h0000_00ff, 12},
    '{1, SRL, RAW, 32'h0000_0009, LIT, 32'h0000_0002, 13},
    '{1, XOR, LIT, 32'h0000_5a5a, RAW, 32'h0000_0009, 14},
    '{1, ADD, RAW, 32'h0000_0009, RAW, 32'h0000_0009, 15},
    // after the flush the first op produces tag 9 and would wake any survivor
    '{0, ADD, LIT, 32'h0000_0007, LIT, 32'h0000_0008, 9},
    '{1, SUB, 30,  32'h0,         LIT, 32'h0000_0002, 7},
    '{0, SLL, 31,  32'h0,         LIT, 32'h0000_0003, 8},
    '{1, SLT, 32,  32'h0,         LIT, 32'h0000_0080, 6}
};

//--- tests/tb_int_exec.sv
`timescale 1ns/100ps

module tb_int_exec;
    import tomasulo_pkg::*;

    `include "tb_int_exec_table.svh"

    localparam int RS_DEPTH  = 4;
    localparam int RAND_ROWS = 40;
    localparam int ROW_COUNT = TABLE_ROWS + RAND_ROWS;
    localparam int NUM_TAGS  = 1 << ROB_TAG_W;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                flush;
    rs_dispatch_t        dispatch_a;
    rs_dispatch_t        dispatch_b;
    logic                full_a;
    logic                full_b;
    cdb_t                cdb;
    row_t                rows [ROW_COUNT];
    logic [XLEN-1:0]     exp_val [ROW_COUNT];
    logic                have_exp [ROW_COUNT];
    logic                row_done [ROW_COUNT];
    logic [NUM_TAGS-1:0] tag_busy;
    int                  tag_row [NUM_TAGS];
    logic                full_b_seen;
    int                  errors;
    integer              seed;

    int_exec_top #(
        .RS_DEPTH (RS_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .dispatch_a_i (dispatch_a),
        .dispatch_b_i (dispatch_b),
        .full_a_o     (full_a),
        .full_b_o     (full_b),
        .cdb_o        (cdb)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // reference results from the opcode rules
    function automatic logic [XLEN-1:0] model_result(input alu_op_e op,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 1'b1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            // signs differ means the negative one is smaller
            default: return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
        endcase
    endfunction

    function automatic logic operand_known(input int dep);
        if (dep == RAW) begin
            return 1'b0;
        end
        return (dep == LIT) ? 1'b1 : have_exp[dep];
    endfunction

    // producers may sit later in the table, so sweep until all resolve
    function automatic void compute_expected();
        for (int pass = 0; pass < ROW_COUNT; pass++) begin
            for (int i = 0; i < ROW_COUNT; i++) begin
                if (!have_exp[i] && operand_known(rows[i].dep1) && operand_known(rows[i].dep2)) begin
                    exp_val[i]  = model_result(rows[i].op,
                        (rows[i].dep1 == LIT) ? rows[i].val1 : exp_val[rows[i].dep1],
                        (rows[i].dep2 == LIT) ? rows[i].val2 : exp_val[rows[i].dep2]);
                    have_exp[i] = 1'b1;
                end
            end
        end
    endfunction

    // value once the producer has shown up on the cdb, tag before that
    function automatic src_t make_src(input int dep, input logic [XLEN-1:0] val);
        src_t s;
        s = '0;
        if (dep == LIT) begin
            s.ready      = 1'b1;
            s.word.value = val;
        end else if (dep == RAW) begin
            s.word.producer.tag = rob_tag_t'(val);
        end else if (row_done[dep]) begin
            s.ready      = 1'b1;
            s.word.value = exp_val[dep];
        end else begin
            s.word.producer.tag = rob_tag_t'(rows[dep].dest);
        end
        return s;
    endfunction

    function automatic rs_dispatch_t build_dispatch(input int idx);
        rs_dispatch_t d;
        d = '0;
        if (idx >= 0) begin
            d.valid = 1'b1;
            d.op    = rows[idx].op;
            d.dest  = rob_tag_t'(rows[idx].dest);
            d.src1  = make_src(rows[idx].dep1, rows[idx].val1);
            d.src2  = make_src(rows[idx].dep2, rows[idx].val2);
        end
        return d;
    endfunction

    // rows go out in order, at most one per cluster per cycle
    task automatic send_rows(input int first, input int last);
        int   next;
        int   slot [2];
        int   idle;
        logic progress;
        next    = first;
        slot[0] = -1;
        slot[1] = -1;
        idle    = 0;
        while (next <= last || slot[0] >= 0 || slot[1] >= 0) begin
            @(posedge clk);
            while (next <= last && slot[rows[next].cluster] < 0 && !tag_busy[rows[next].dest]) begin
                slot[rows[next].cluster]  = next;
                tag_busy[rows[next].dest] = 1'b1;
                tag_row[rows[next].dest]  = next;
                next++;
            end
            // sources are rebuilt on every retry so a missed broadcast turns into a value
            dispatch_a <= build_dispatch(slot[0]);
            dispatch_b <= build_dispatch(slot[1]);
            @(negedge clk);
            progress = (slot[0] >= 0 && !full_a) || (slot[1] >= 0 && !full_b);
            if (!full_a) begin
                slot[0] = -1;
            end
            if (!full_b) begin
                slot[1] = -1;
            end
            idle = progress ? 0 : idle + 1;
            if (idle > 200) begin
                stop_on_error("timeout: no dispatch accepted for 200 cycles");
            end
        end
        @(posedge clk);
        dispatch_a <= '0;
        dispatch_b <= '0;
    endtask

    task automatic wait_all_done();
        int waited;
        waited = 0;
        while (tag_busy != '0) begin
            @(posedge clk);
            waited++;
            if (waited > 500) begin
                stop_on_error("timeout: results still missing on the CDB");
            end
        end
    endtask

    // scoreboard on the broadcast, any tag not in flight is an error
    always @(negedge clk) begin
        if (rst_n && cdb.valid) begin
            if (!tag_busy[cdb.tag]) begin
                stop_on_error($sformatf("unexpected result for tag %0d on the CDB", cdb.tag));
            end else begin
                compare_word(cdb.value, exp_val[tag_row[cdb.tag]],
                             $sformatf("result of tag %0d", cdb.tag));
                row_done[tag_row[cdb.tag]] = 1'b1;
                tag_busy[cdb.tag]          = 1'b0;
            end
        end
        if (full_b) begin
            full_b_seen = 1'b1;
        end
    end

    initial begin
        logic [31:0] rand_word;
        seed        = 32'hef04321a;
        rst_n       = 1'b0;
        flush       = 1'b0;
        dispatch_a  = '0;
        dispatch_b  = '0;
        tag_busy    = '0;
        full_b_seen = 1'b0;
        errors      = 0;
        for (int i = 0; i < ROW_COUNT; i++) begin
            have_exp[i] = 1'b0;
            row_done[i] = 1'b0;
        end
        for (int i = 0; i < TABLE_ROWS; i++) begin
            rows[i] = table_rows[i];
        end
        // independent random ops for the two-cluster stream
        for (int i = TABLE_ROWS; i < ROW_COUNT; i++) begin
            rand_word       = $random(seed);
            rows[i].cluster = rand_word[3];
            rows[i].op      = alu_op_e'(rand_word[2:0]);
            rows[i].dep1    = LIT;
            rows[i].val1    = $random(seed);
            rows[i].dep2    = LIT;
            rows[i].val2    = $random(seed);
            rows[i].dest    = i % NUM_TAGS;
        end
        compute_expected();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        send_rows(0, OPS_END - 1);
        wait_all_done();
        send_rows(OPS_END, CHAIN_END - 1);
        wait_all_done();
        send_rows(CHAIN_END, FULL_END - 1);
        wait_all_done();
        compare_word(XLEN'(full_b_seen), 1, "full_b_o while cluster b waited");
        send_rows(TABLE_ROWS, ROW_COUNT - 1);
        wait_all_done();

        // park ops on a tag that never comes, then flush them
        send_rows(FULL_END, FLUSH_END - 1);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
        tag_busy = '0;
        @(negedge clk);
        compare_word(XLEN'(full_a), 0, "full_a_o after flush");
        compare_word(XLEN'(full_b), 0, "full_b_o after flush");
        repeat (12) @(posedge clk);
        send_rows(FLUSH_END, TABLE_ROWS - 1);
        wait_all_done();

        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/int_exec_top.sv
`timescale 1ns/100ps

module int_exec_top #(
    parameter int RS_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  tomasulo_pkg::rs_dispatch_t   dispatch_a_i,
    input  tomasulo_pkg::rs_dispatch_t   dispatch_b_i,
    output logic                         full_a_o,
    output logic                         full_b_o,
    output tomasulo_pkg::cdb_t           cdb_o
);
    import tomasulo_pkg::*;

    alu_result_t result_a;
    alu_result_t result_b;
    logic        grant_a;
    logic        grant_b;
    cdb_t        cdb;

    // cluster a
    alu_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs_a (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_a_i),
        .cdb_i      (cdb),
        .grant_i    (grant_a),
        .full_o     (full_a_o),
        .result_o   (result_a)
    );

    // cluster b
    alu_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs_b (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_b_i),
        .cdb_i      (cdb),
        .grant_i    (grant_b),
        .full_o     (full_b_o),
        .result_o   (result_b)
    );

    cdb_arbiter u_cdb_arb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .result_a_i (result_a),
        .result_b_i (result_b),
        .grant_a_o  (grant_a),
        .grant_b_o  (grant_b),
        .cdb_o      (cdb)
    );

    // registered broadcast doubles as the subsystem output
    assign cdb_o = cdb;

endmodule

//--- verilog/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  tomasulo_pkg::alu_result_t   result_a_i,
    input  tomasulo_pkg::alu_result_t   result_b_i,
    output logic                        grant_a_o,
    output logic                        grant_b_o,
    output tomasulo_pkg::cdb_t          cdb_o
);
    import tomasulo_pkg::*;

    // high when b lost the last contention
    logic            prio_b_q;
    logic            both_valid;
    logic            grant_a;
    logic            grant_b;

    logic            cdb_valid_q;
    rob_tag_t        cdb_tag_q;
    logic [XLEN-1:0] cdb_value_q;

    assign both_valid = result_a_i.valid && result_b_i.valid;

    assign grant_a = result_a_i.valid && (!result_b_i.valid || !prio_b_q);
    assign grant_b = result_b_i.valid && (!result_a_i.valid || prio_b_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_b_q    <= 1'b0;
            cdb_valid_q <= 1'b0;
        end else if (flush_i) begin
            prio_b_q    <= 1'b0;
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= grant_a || grant_b;
            // loser of a tie goes first next time
            if (both_valid) begin
                prio_b_q <= grant_a;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_a) begin
            cdb_tag_q   <= result_a_i.tag;
            cdb_value_q <= result_a_i.value;
        end else if (grant_b) begin
            cdb_tag_q   <= result_b_i.tag;
            cdb_value_q <= result_b_i.value;
        end
    end

    assign grant_a_o = grant_a;
    assign grant_b_o = grant_b;

    assign cdb_o.valid = cdb_valid_q;
    assign cdb_o.tag   = cdb_tag_q;
    assign cdb_o.value = cdb_value_q;

endmodule

//--- verilog/alu_rs.sv
`timescale 1ns/100ps

module alu_rs #(
    parameter int RS_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  tomasulo_pkg::rs_dispatch_t   dispatch_i,
    input  tomasulo_pkg::cdb_t           cdb_i,
    input  logic                         grant_i,
    output logic                         full_o,
    output tomasulo_pkg::alu_result_t    result_o
);
    import tomasulo_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    typedef struct packed {
        alu_op_e  op;
        rob_tag_t dest;
        src_t     src1;
        src_t     src2;
    } rs_entry_t;

    rs_entry_t           entries [RS_DEPTH];
    logic [RS_DEPTH-1:0] in_use_q;
    logic [RS_DEPTH-1:0] in_use_d;
    logic [RS_DEPTH-1:0] ready_vec;
    logic                full_q;

    logic                alloc_hit;
    logic [IDX_W-1:0]    alloc_idx;
    logic                issue_hit;
    logic [IDX_W-1:0]    issue_idx;
    logic                do_alloc;
    logic                do_issue;
    logic                alu_busy;
    rs_entry_t           issue_entry;

    // grab the cdb value when a waiting source sees its producer tag
    function automatic src_t capture(input src_t src, input cdb_t cdb);
        src_t res;
        res = src;
        if (!src.ready && cdb.valid && src.word.producer.tag == cdb.tag) begin
            res.ready      = 1'b1;
            res.word.value = cdb.value;
        end
        return res;
    endfunction

    // lowest free slot
    always_comb begin
        alloc_hit = 1'b0;
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!in_use_q[i]) begin
                alloc_hit = 1'b1;
                alloc_idx = IDX_W'(i);
            end
        end
    end

    // both operands present
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_vec[i] = in_use_q[i] && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // lowest ready entry goes to the alu
    always_comb begin
        issue_hit = 1'b0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                issue_hit = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign do_alloc    = dispatch_i.valid && !full_q && alloc_hit;
    assign do_issue    = issue_hit && !alu_busy;
    assign issue_entry = entries[issue_idx];

    // occupancy after this edge, freed slot is only reusable next cycle
    always_comb begin
        in_use_d = in_use_q;
        if (do_issue) begin
            in_use_d[issue_idx] = 1'b0;
        end
        if (do_alloc) begin
            in_use_d[alloc_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_use_q <= '0;
            full_q   <= 1'b0;
        end else if (flush_i) begin
            in_use_q <= '0;
            full_q   <= 1'b0;
        end else begin
            in_use_q <= in_use_d;
            full_q   <= &in_use_d;
        end
    end

    // entry payload: new dispatch or cdb wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (do_alloc && alloc_idx == IDX_W'(i)) begin
                entries[i].op   <= dispatch_i.op;
                entries[i].dest <= dispatch_i.dest;
                entries[i].src1 <= capture(dispatch_i.src1, cdb_i);
                entries[i].src2 <= capture(dispatch_i.src2, cdb_i);
            end else begin
                entries[i].src1 <= capture(entries[i].src1, cdb_i);
                entries[i].src2 <= capture(entries[i].src2, cdb_i);
            end
        end
    end

    assign full_o = full_q;

    int_alu u_alu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .issue_i  (do_issue),
        .op_i     (issue_entry.op),
        .a_i      (issue_entry.src1.word.value),
        .b_i      (issue_entry.src2.word.value),
        .tag_i    (issue_entry.dest),
        .grant_i  (grant_i),
        .busy_o   (alu_busy),
        .result_o (result_o)
    );

endmodule

//--- verilog/int_alu.sv
`timescale 1ns/100ps

module int_alu (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  logic                             issue_i,
    input  tomasulo_pkg::alu_op_e            op_i,
    input  logic [tomasulo_pkg::XLEN-1:0]    a_i,
    input  logic [tomasulo_pkg::XLEN-1:0]    b_i,
    input  tomasulo_pkg::rob_tag_t           tag_i,
    input  logic                             grant_i,
    output logic                             busy_o,
    output tomasulo_pkg::alu_result_t        result_o
);
    import tomasulo_pkg::*;

    logic [XLEN-1:0] alu_value;
    logic            slt_bit;
    logic            res_valid_q;
    rob_tag_t        res_tag_q;
    logic [XLEN-1:0] res_value_q;

    assign slt_bit = $signed(a_i) < $signed(b_i);

    // shifts only look at the low 5 bits of b
    always_comb begin
        case (op_i)
            ADD:     alu_value = a_i + b_i;
            SUB:     alu_value = a_i - b_i;
            AND:     alu_value = a_i & b_i;
            OR:      alu_value = a_i | b_i;
            XOR:     alu_value = a_i ^ b_i;
            SLL:     alu_value = a_i << b_i[4:0];
            SRL:     alu_value = a_i >> b_i[4:0];
            SLT:     alu_value = {{(XLEN-1){1'b0}}, slt_bit};
            default: alu_value = '0;
        endcase
    end

    // result stays put until the arbiter takes it
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else if (issue_i) begin
            res_valid_q <= 1'b1;
        end else if (grant_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            res_tag_q   <= tag_i;
            res_value_q <= alu_value;
        end
    end

    // a granted result frees the register at this edge
    assign busy_o = res_valid_q && !grant_i;

    assign result_o.valid = res_valid_q;
    assign result_o.tag   = res_tag_q;
    assign result_o.value = res_value_q;

endmodule

//--- verilog/tomasulo_pkg.sv
package tomasulo_pkg;

    // datapath and tag widths
    localparam int XLEN      = 32;
    localparam int ROB_TAG_W = 4;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // rv32i integer ops handled by the execute clusters
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // producer view of an operand word, tag in the low bits
    typedef struct packed {
        logic [XLEN-ROB_TAG_W-1:0] unused;
        rob_tag_t                  tag;
    } producer_t;

    // same word, read as data once ready and as a tag while waiting
    typedef union packed {
        logic [XLEN-1:0] value;
        producer_t       producer;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u word;
    } src_t;

    // one op from the decoder
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        rob_tag_t dest;
        src_t     src1;
        src_t     src2;
    } rs_dispatch_t;

    // common data bus broadcast
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
    } cdb_t;

    // cluster result towards the arbiter, same layout as the cdb
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [XLEN-1:0] value;
    } alu_result_t;

endpackage
